//--- compile.f
+incdir+verif
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/cpu_top.sv
verif/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module cpu_tb -f compile.f -o cpu_sim \
  && ./obj_dir/cpu_sim | tee /dev/stderr | grep -q "^Everything OK$" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation FAILED"; exit 1; }

//--- verif/cpu_ref_model.svh
// Program image, rebuilt for every run
cpu_pkg::word_t    prog [128];
int                prog_len;

// Expected retirement trace and halt address
cpu_pkg::reg_idx_t exp_reg_q [$];
cpu_pkg::word_t    exp_data_q [$];
cpu_pkg::word_t    exp_pc;

// Condition codes against the stored N, V, Z
function automatic logic cond_true(input logic [2:0] c, input cpu_pkg::flags_t f);
  case (cpu_pkg::cond_e'(c))
    cpu_pkg::COND_NE: return !f.z;
    cpu_pkg::COND_EQ: return f.z;
    cpu_pkg::COND_GT: return !f.z && !f.n;
    cpu_pkg::COND_LT: return f.n;
    cpu_pkg::COND_GE: return f.z || !f.n;
    cpu_pkg::COND_LE: return f.n || f.z;
    cpu_pkg::COND_OV: return f.v;
    default: return 1'b1;
  endcase
endfunction

task automatic build_program();
  bit             landing [128];
  int             idx;
  int             hlt_idx;
  int             kind;
  int             tgt;
  cpu_pkg::word_t base;
  logic [7:0]     lo;
  logic [7:0]     hi;
  logic [2:0]     cond;
  for (int i = 0; i < 128; i++) begin
    landing[i] = 1'b0;
  end
  // r15 is the data base pointer, even byte address
  base = 16'($urandom) & 16'hfffe;
  idx  = 0;
  // LLB and LHB pair per register, LLB sees the reset value
  for (int r = 0; r < 16; r++) begin
    lo = 8'($urandom);
    hi = 8'($urandom);
    // r14 carries BR targets, high byte kept clear
    if (r == 14) begin
      hi = 8'h00;
    end
    if (r == 15) begin
      lo = base[7:0];
      hi = base[15:8];
    end
    prog[idx]     = {cpu_pkg::OP_LLB, 4'(r), lo};
    prog[idx + 1] = {cpu_pkg::OP_LHB, 4'(r), hi};
    idx += 2;
  end
  // Fill all 16 words reachable from r15 so every LW reads stored data
  for (int k = 0; k < 16; k++) begin
    prog[idx] = {cpu_pkg::OP_SW, 4'($urandom_range(15, 0)), 4'hf, 4'(k)};
    idx++;
  end
  hlt_idx = idx + 40 + $urandom_range(29, 0);
  while (idx < hlt_idx) begin
    kind = $urandom_range(9, 0);
    cond = 3'($urandom_range(7, 0));
    if (kind == 9 && idx + 1 < hlt_idx && !landing[idx + 1]) begin
      // LLB r14 then BR, nothing ever jumps onto the BR itself
      tgt = idx + 2 + $urandom_range(4, 0);
      tgt = (tgt > hlt_idx) ? hlt_idx : tgt;
      landing[tgt]  = 1'b1;
      prog[idx]     = {cpu_pkg::OP_LLB, 4'd14, 8'(tgt * 2)};
      prog[idx + 1] = {cpu_pkg::OP_BR, cond, 1'b0, 4'd14, 4'd0};
      idx += 2;
    end else begin
      if (kind == 8) begin
        // Forward only, never past HLT
        tgt = idx + 1 + $urandom_range(4, 0);
        tgt = (tgt > hlt_idx) ? hlt_idx : tgt;
        landing[tgt] = 1'b1;
        prog[idx]    = {cpu_pkg::OP_B, cond, 9'(tgt - idx - 1)};
      end else if (kind == 7) begin
        prog[idx] = {cpu_pkg::OP_PCS, 4'($urandom_range(13, 0)), 8'h00};
      end else if (kind == 6) begin
        prog[idx] = {($urandom_range(1, 0) == 1) ? cpu_pkg::OP_LHB : cpu_pkg::OP_LLB,
                     4'($urandom_range(13, 0)), 8'($urandom)};
      end else if (kind == 5) begin
        prog[idx] = {($urandom_range(1, 0) == 1) ? cpu_pkg::OP_SW : cpu_pkg::OP_LW,
                     4'($urandom_range(13, 0)), 4'hf, 4'($urandom)};
      end else begin
        // ALU ops 0 to 6, rd may be r0
        prog[idx] = {4'($urandom_range(6, 0)), 4'($urandom_range(13, 0)),
                     4'($urandom), 4'($urandom)};
      end
      idx++;
    end
  end
  prog[hlt_idx] = {cpu_pkg::OP_HLT, 12'h000};
  prog_len      = hlt_idx + 1;
endtask

// Instruction-level execution of prog, one word per step
task automatic run_model();
  cpu_pkg::word_t    regs [16];
  cpu_pkg::word_t    mem [256];
  cpu_pkg::flags_t   fl;
  cpu_pkg::word_t    pc_m;
  cpu_pkg::word_t    next_pc;
  cpu_pkg::word_t    ins;
  cpu_pkg::word_t    a;
  cpu_pkg::word_t    b;
  cpu_pkg::word_t    res;
  cpu_pkg::word_t    addr;
  cpu_pkg::reg_idx_t rd;
  logic [3:0]        imm4;
  logic [16:0]       wide;
  logic              wr;
  logic              halted;
  for (int i = 0; i < 16; i++) begin
    regs[i] = '0;
  end
  exp_reg_q.delete();
  exp_data_q.delete();
  fl     = '0;
  pc_m   = '0;
  exp_pc = 16'hffff;
  halted = 1'b0;
  for (int step = 0; step < 1000 && !halted; step++) begin
    ins     = prog[pc_m[7:1]];
    rd      = ins[11:8];
    imm4    = ins[3:0];
    a       = regs[ins[7:4]];
    b       = regs[ins[3:0]];
    addr    = a + {{11{imm4[3]}}, imm4, 1'b0};
    res     = '0;
    wr      = 1'b0;
    next_pc = pc_m + 16'd2;
    case (cpu_pkg::opcode_e'(ins[15:12]))
      cpu_pkg::OP_ADD, cpu_pkg::OP_SUB: begin
        // 17-bit signed result, overflow when the top two bits differ
        wide = ins[12] ? {a[15], a} - {b[15], b} : {a[15], a} + {b[15], b};
        res  = wide[15:0];
        wr   = 1'b1;
        fl.n = res[15];
        fl.v = wide[16] ^ wide[15];
        fl.z = (res == '0);
      end
      cpu_pkg::OP_XOR, cpu_pkg::OP_AND, cpu_pkg::OP_SLL, cpu_pkg::OP_SRA, cpu_pkg::OP_ROR: begin
        if (ins[15:12] == 4'h2) begin
          res = a ^ b;
        end else if (ins[15:12] == 4'h3) begin
          res = a & b;
        end else if (ins[15:12] == 4'h4) begin
          res = a << imm4;
        end else begin
          // One bit at a time, SRA refills the sign, ROR the dropped bit
          res = a;
          repeat (imm4) res = {(ins[12] ? res[15] : res[0]), res[15:1]};
        end
        wr   = 1'b1;
        fl.z = (res == '0);
      end
      cpu_pkg::OP_LW: begin
        res = mem[addr[8:1]];
        wr  = 1'b1;
      end
      cpu_pkg::OP_SW: mem[addr[8:1]] = regs[rd];
      cpu_pkg::OP_LLB: begin
        res = {regs[rd][15:8], ins[7:0]};
        wr  = 1'b1;
      end
      cpu_pkg::OP_LHB: begin
        res = {ins[7:0], regs[rd][7:0]};
        wr  = 1'b1;
      end
      cpu_pkg::OP_B: begin
        if (cond_true(ins[11:9], fl)) begin
          next_pc = pc_m + 16'd2 + {{6{ins[8]}}, ins[8:0], 1'b0};
        end
      end
      cpu_pkg::OP_BR: begin
        if (cond_true(ins[11:9], fl)) begin
          next_pc = a;
        end
      end
      cpu_pkg::OP_PCS: begin
        res = pc_m + 16'd2;
        wr  = 1'b1;
      end
      cpu_pkg::OP_HLT: begin
        exp_pc = pc_m;
        halted = 1'b1;
      end
      default: ;
    endcase
    // r0 writes vanish
    if (wr && rd != 4'd0) begin
      regs[rd] = res;
      exp_reg_q.push_back(rd);
      exp_data_q.push_back(res);
    end
    pc_m = halted ? pc_m : next_pc;
  end
endtask

//--- verif/cpu_tb.sv
module cpu_tb;

  localparam int IMEM_ADDR_W = 8;
  localparam int DMEM_ADDR_W = 8;
  localparam int NUM_PROGS   = 20;
  // Cycle limit for one program to reach HLT
  localparam int RUN_TIMEOUT = 2000;

  logic                   clk;
  logic                   rst_n;
  logic                   imem_we;
  logic [IMEM_ADDR_W-1:0] imem_addr;
  cpu_pkg::word_t         imem_wdata;
  logic                   hlt;
  cpu_pkg::word_t         pc;
  logic                   wb_en;
  cpu_pkg::reg_idx_t      wb_reg;
  cpu_pkg::word_t         wb_data;

  `include "cpu_ref_model.svh"

  cpu_top #(
    .IMEM_ADDR_W(IMEM_ADDR_W),
    .DMEM_ADDR_W(DMEM_ADDR_W)
  ) DUT (
    .clk(clk),
    .rst_n(rst_n),
    .imem_we(imem_we),
    .imem_addr(imem_addr),
    .imem_wdata(imem_wdata),
    .hlt(hlt),
    .pc(pc),
    .wb_en(wb_en),
    .wb_reg(wb_reg),
    .wb_data(wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_wb(input cpu_pkg::reg_idx_t got_reg, input cpu_pkg::word_t got_data,
                          input cpu_pkg::reg_idx_t exp_reg, input cpu_pkg::word_t exp_data);
    if (got_reg !== exp_reg || got_data !== exp_data) begin
      abort_run($sformatf("CHECK FAILED at time %0t: write r%0d = %h, expected r%0d = %h",
                          $time, got_reg, got_data, exp_reg, exp_data));
    end
  endtask

  task automatic check_pc(input cpu_pkg::word_t got, input cpu_pkg::word_t exp_val);
    if (got !== exp_val) begin
      abort_run($sformatf("CHECK FAILED at time %0t: pc is %h, expected %h",
                          $time, got, exp_val));
    end
  endtask

  // Core held in reset while the image goes in, then 16 more reset cycles
  task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
      @(posedge clk);
      rst_n      <= 1'b0;
      imem_we    <= 1'b1;
      imem_addr  <= IMEM_ADDR_W'(i);
      imem_wdata <= prog[i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  // Trace sampled mid-cycle, well clear of the edges
  task automatic run_program(input int prog_num);
    int                cycles;
    int                seen;
    cpu_pkg::reg_idx_t exp_reg;
    cpu_pkg::word_t    exp_data;
    cycles = 0;
    seen   = 0;
    @(negedge clk);
    while (!hlt) begin
      if (wb_en) begin
        if (exp_reg_q.size() == 0) begin
          abort_run($sformatf("Program %0d wrote r%0d after the expected trace ended",
                              prog_num, wb_reg));
        end else begin
          exp_reg  = exp_reg_q.pop_front();
          exp_data = exp_data_q.pop_front();
          check_wb(wb_reg, wb_data, exp_reg, exp_data);
          seen++;
        end
      end
      cycles++;
      if (cycles > RUN_TIMEOUT) begin
        abort_run($sformatf("Program %0d: the core never halted within %0d cycles",
                            prog_num, RUN_TIMEOUT));
      end
      @(negedge clk);
    end
    if (wb_en) begin
      abort_run($sformatf("Program %0d: a register write retired with HLT", prog_num));
    end
    check_pc(pc, exp_pc);
    if (exp_reg_q.size() != 0) begin
      abort_run($sformatf("Program %0d halted with %0d expected writes missing",
                          prog_num, exp_reg_q.size()));
    end
    // Halted core must stay put and silent
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      if (!hlt || wb_en) begin
        abort_run($sformatf("Program %0d: halt dropped or a write appeared after HLT",
                            prog_num));
      end
      check_pc(pc, exp_pc);
    end
    $display("program %0d: %0d words, %0d writes matched", prog_num, prog_len, seen);
  endtask

  initial begin
    int seed_val;
    rst_n      = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    seed_val   = $urandom(32'h7aec);
    for (int p = 0; p < NUM_PROGS; p++) begin
      build_program();
      run_model();
      load_program();
      run_program(p);
    end
    $display("Everything OK");
    $finish;
  end

endmodule

//--- logic/cpu_top.sv
module cpu_top #(
  parameter int IMEM_ADDR_W = 8,
  parameter int DMEM_ADDR_W = 8
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   imem_we,
  input  logic [IMEM_ADDR_W-1:0] imem_addr,
  input  cpu_pkg::word_t         imem_wdata,
  output logic                   hlt,
  output cpu_pkg::word_t         pc,
  output logic                   wb_en,
  output cpu_pkg::reg_idx_t      wb_reg,
  output cpu_pkg::word_t         wb_data
);

  // Fetch outputs
  cpu_pkg::word_t        instr;
  cpu_pkg::word_t        pc_plus2;

  // Decode outputs
  cpu_pkg::word_t        alu_a;
  cpu_pkg::word_t        alu_b;
  cpu_pkg::alu_op_e      alu_op;
  logic                  flag_we;
  cpu_pkg::branch_kind_e branch_kind;
  cpu_pkg::cond_e        cond;
  cpu_pkg::word_t        branch_offset;
  cpu_pkg::word_t        rs_data;
  cpu_pkg::word_t        store_data;
  logic                  mem_read;
  logic                  mem_write;
  cpu_pkg::wb_sel_e      wb_sel;
  cpu_pkg::reg_idx_t     rd;
  logic                  reg_we;
  logic                  halt_instr;

  // Execute outputs
  cpu_pkg::word_t        alu_result;
  logic                  take_branch;
  cpu_pkg::word_t        branch_target;

  fetch_stage #(
    .IMEM_ADDR_W(IMEM_ADDR_W)
  ) u_fetch (
    .clk(clk),
    .rst_n(rst_n),
    .imem_we(imem_we),
    .imem_addr(imem_addr),
    .imem_wdata(imem_wdata),
    .halt_instr(halt_instr),
    .take_branch(take_branch),
    .branch_target(branch_target),
    .instr(instr),
    .pc(pc),
    .pc_plus2(pc_plus2),
    .hlt(hlt)
  );

  decode_stage u_decode (
    .clk(clk),
    .rst_n(rst_n),
    .instr(instr),
    .pc_plus2(pc_plus2),
    .hlt(hlt),
    .wb_data(wb_data),
    .alu_a(alu_a),
    .alu_b(alu_b),
    .alu_op(alu_op),
    .flag_we(flag_we),
    .branch_kind(branch_kind),
    .cond(cond),
    .branch_offset(branch_offset),
    .rs_data(rs_data),
    .store_data(store_data),
    .mem_read(mem_read),
    .mem_write(mem_write),
    .wb_sel(wb_sel),
    .rd(rd),
    .reg_we(reg_we),
    .halt_instr(halt_instr)
  );

  execute_stage u_execute (
    .clk(clk),
    .rst_n(rst_n),
    .alu_a(alu_a),
    .alu_b(alu_b),
    .alu_op(alu_op),
    .flag_we(flag_we),
    .branch_kind(branch_kind),
    .cond(cond),
    .branch_offset(branch_offset),
    .rs_data(rs_data),
    .pc_plus2(pc_plus2),
    .alu_result(alu_result),
    .take_branch(take_branch),
    .branch_target(branch_target)
  );

  memory_stage #(
    .DMEM_ADDR_W(DMEM_ADDR_W)
  ) u_memory (
    .clk(clk),
    .mem_read(mem_read),
    .mem_write(mem_write),
    .alu_result(alu_result),
    .store_data(store_data),
    .wb_sel(wb_sel),
    .pc_plus2(pc_plus2),
    .wb_data(wb_data)
  );

  // Retirement trace of the register write port
  assign wb_en  = reg_we;
  assign wb_reg = rd;

endmodule

//--- logic/memory_stage.sv
module memory_stage #(
  parameter int DMEM_ADDR_W = 8
) (
  input  logic             clk,
  input  logic             mem_read,
  input  logic             mem_write,
  input  cpu_pkg::word_t   alu_result,
  input  cpu_pkg::word_t   store_data,
  input  cpu_pkg::wb_sel_e wb_sel,
  input  cpu_pkg::word_t   pc_plus2,
  output cpu_pkg::word_t   wb_data
);

  cpu_pkg::word_t         dmem [2**DMEM_ADDR_W];
  logic [DMEM_ADDR_W-1:0] word_addr;
  cpu_pkg::word_t         load_data;

  // Byte address to word index
  assign word_addr = alu_result[DMEM_ADDR_W:1];

  always_ff @(posedge clk) begin
    if (mem_write) begin
      dmem[word_addr] <= store_data;
    end
  end

  // Asynchronous read, zero when not a load
  assign load_data = mem_read ? dmem[word_addr] : '0;

  // Write-back select
  always_comb begin
    case (wb_sel)
      cpu_pkg::WB_MEM: wb_data = load_data;
      cpu_pkg::WB_PC2: wb_data = pc_plus2;
      default: wb_data = alu_result;
    endcase
  end

endmodule

//--- logic/execute_stage.sv
module execute_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cpu_pkg::word_t        alu_a,
  input  cpu_pkg::word_t        alu_b,
  input  cpu_pkg::alu_op_e      alu_op,
  input  logic                  flag_we,
  input  cpu_pkg::branch_kind_e branch_kind,
  input  cpu_pkg::cond_e        cond,
  input  cpu_pkg::word_t        branch_offset,
  input  cpu_pkg::word_t        rs_data,
  input  cpu_pkg::word_t        pc_plus2,
  output cpu_pkg::word_t        alu_result,
  output logic                  take_branch,
  output cpu_pkg::word_t        branch_target
);

  cpu_pkg::word_t  sum;
  cpu_pkg::word_t  diff;
  logic [31:0]     rot;
  logic [3:0]      shamt;
  logic            v_add;
  logic            v_sub;
  logic            arith;
  logic            cond_met;
  cpu_pkg::flags_t flags_q;
  cpu_pkg::flags_t flags_d;

  assign sum   = alu_a + alu_b;
  assign diff  = alu_a - alu_b;
  assign shamt = alu_b[3:0];

  // Rotate by shifting a doubled copy
  assign rot = {alu_a, alu_a} >> shamt;

  // Signed overflow, operands agree but result sign differs
  assign v_add = (alu_a[15] == alu_b[15]) && (sum[15] != alu_a[15]);
  assign v_sub = (alu_a[15] != alu_b[15]) && (diff[15] != alu_a[15]);

  always_comb begin
    case (alu_op)
      cpu_pkg::ALU_ADD: alu_result = sum;
      cpu_pkg::ALU_SUB: alu_result = diff;
      cpu_pkg::ALU_XOR: alu_result = alu_a ^ alu_b;
      cpu_pkg::ALU_AND: alu_result = alu_a & alu_b;
      cpu_pkg::ALU_SLL: alu_result = alu_a << shamt;
      cpu_pkg::ALU_SRA: alu_result = $signed(alu_a) >>> shamt;
      cpu_pkg::ALU_ROR: alu_result = rot[15:0];
      default: alu_result = alu_b;
    endcase
  end

  // N and V only move on ADD and SUB
  assign arith = (alu_op == cpu_pkg::ALU_ADD) || (alu_op == cpu_pkg::ALU_SUB);

  always_comb begin
    flags_d.n = arith ? alu_result[15] : flags_q.n;
    flags_d.z = (alu_result == '0);
    if (alu_op == cpu_pkg::ALU_ADD) begin
      flags_d.v = v_add;
    end else if (alu_op == cpu_pkg::ALU_SUB) begin
      flags_d.v = v_sub;
    end else begin
      flags_d.v = flags_q.v;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags_q <= '0;
    end else if (flag_we) begin
      flags_q <= flags_d;
    end
  end

  // Condition test against stored flags only
  always_comb begin
    case (cond)
      cpu_pkg::COND_NE: cond_met = ~flags_q.z;
      cpu_pkg::COND_EQ: cond_met = flags_q.z;
      cpu_pkg::COND_GT: cond_met = ~flags_q.z & ~flags_q.n;
      cpu_pkg::COND_LT: cond_met = flags_q.n;
      cpu_pkg::COND_GE: cond_met = flags_q.z | ~flags_q.n;
      cpu_pkg::COND_LE: cond_met = flags_q.n | flags_q.z;
      cpu_pkg::COND_OV: cond_met = flags_q.v;
      default: cond_met = 1'b1;
    endcase
  end

  assign take_branch = (branch_kind != cpu_pkg::BR_NONE) && cond_met;

  // BR jumps to rs, B is PC relative
  assign branch_target = (branch_kind == cpu_pkg::BR_REG) ? rs_data
                                                          : pc_plus2 + branch_offset;

endmodule

//--- logic/decode_stage.sv
module decode_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cpu_pkg::word_t        instr,
  input  cpu_pkg::word_t        pc_plus2,
  input  logic                  hlt,
  input  cpu_pkg::word_t        wb_data,
  output cpu_pkg::word_t        alu_a,
  output cpu_pkg::word_t        alu_b,
  output cpu_pkg::alu_op_e      alu_op,
  output logic                  flag_we,
  output cpu_pkg::branch_kind_e branch_kind,
  output cpu_pkg::cond_e        cond,
  output cpu_pkg::word_t        branch_offset,
  output cpu_pkg::word_t        rs_data,
  output cpu_pkg::word_t        store_data,
  output logic                  mem_read,
  output logic                  mem_write,
  output cpu_pkg::wb_sel_e      wb_sel,
  output cpu_pkg::reg_idx_t     rd,
  output logic                  reg_we,
  output logic                  halt_instr
);

  cpu_pkg::opcode_e  opcode;
  cpu_pkg::reg_idx_t rs;
  cpu_pkg::reg_idx_t rt;
  cpu_pkg::reg_idx_t src1;
  cpu_pkg::reg_idx_t src2;
  cpu_pkg::word_t    src1_data;
  cpu_pkg::word_t    src2_data;
  cpu_pkg::word_t    imm_mem;
  cpu_pkg::word_t    imm_shift;
  logic [7:0]        imm8;
  logic              writes_reg;
  logic              writes_flags;
  logic              is_store;
  cpu_pkg::word_t    regs [16];

  // Instruction fields
  assign opcode = cpu_pkg::opcode_e'(instr[15:12]);
  assign rd     = instr[11:8];
  assign rs     = instr[7:4];
  assign rt     = instr[3:0];
  assign imm8   = instr[7:0];
  assign cond   = cpu_pkg::cond_e'(instr[11:9]);

  // Immediates, offsets scaled to bytes
  assign branch_offset = {{6{instr[8]}}, instr[8:0], 1'b0};
  assign imm_mem       = {{11{instr[3]}}, instr[3:0], 1'b0};
  assign imm_shift     = {12'h000, instr[3:0]};

  // LLB and LHB modify rd in place; SW stores rd
  assign src1 = (opcode == cpu_pkg::OP_LLB || opcode == cpu_pkg::OP_LHB) ? rd : rs;
  assign src2 = (opcode == cpu_pkg::OP_SW) ? rd : rt;

  // r0 reads as zero
  assign src1_data = (src1 == 4'd0) ? '0 : regs[src1];
  assign src2_data = (src2 == 4'd0) ? '0 : regs[src2];

  assign alu_a      = src1_data;
  assign rs_data    = src1_data;
  assign store_data = src2_data;

  always_comb begin
    alu_b        = src2_data;
    alu_op       = cpu_pkg::ALU_ADD;
    writes_reg   = 1'b0;
    writes_flags = 1'b0;
    is_store     = 1'b0;
    mem_read     = 1'b0;
    branch_kind  = cpu_pkg::BR_NONE;
    wb_sel       = cpu_pkg::WB_ALU;
    halt_instr   = 1'b0;
    case (opcode)
      cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_XOR, cpu_pkg::OP_AND: begin
        alu_op       = cpu_pkg::alu_op_e'(instr[14:12]);
        writes_reg   = 1'b1;
        writes_flags = 1'b1;
      end
      // Shift amount is the raw imm4
      cpu_pkg::OP_SLL, cpu_pkg::OP_SRA, cpu_pkg::OP_ROR: begin
        alu_op       = cpu_pkg::alu_op_e'(instr[14:12]);
        alu_b        = imm_shift;
        writes_reg   = 1'b1;
        writes_flags = 1'b1;
      end
      cpu_pkg::OP_LW: begin
        alu_b      = imm_mem;
        mem_read   = 1'b1;
        writes_reg = 1'b1;
        wb_sel     = cpu_pkg::WB_MEM;
      end
      cpu_pkg::OP_SW: begin
        alu_b    = imm_mem;
        is_store = 1'b1;
      end
      // Byte merge done here, ALU passes it on
      cpu_pkg::OP_LLB: begin
        alu_op     = cpu_pkg::ALU_PASS_B;
        alu_b      = {src1_data[15:8], imm8};
        writes_reg = 1'b1;
      end
      cpu_pkg::OP_LHB: begin
        alu_op     = cpu_pkg::ALU_PASS_B;
        alu_b      = {imm8, src1_data[7:0]};
        writes_reg = 1'b1;
      end
      cpu_pkg::OP_B: branch_kind = cpu_pkg::BR_B;
      cpu_pkg::OP_BR: branch_kind = cpu_pkg::BR_REG;
      // PC+2 also goes through the ALU unchanged
      cpu_pkg::OP_PCS: begin
        alu_op     = cpu_pkg::ALU_PASS_B;
        alu_b      = pc_plus2;
        writes_reg = 1'b1;
        wb_sel     = cpu_pkg::WB_PC2;
      end
      cpu_pkg::OP_HLT: halt_instr = 1'b1;
      default: ;
    endcase
  end

  // No writes in reset or once halted; r0 never written
  assign reg_we    = writes_reg & (rd != 4'd0) & ~hlt & rst_n;
  assign mem_write = is_store & ~hlt & rst_n;
  assign flag_we   = writes_flags & ~hlt & rst_n;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_we) begin
      regs[rd] <= wb_data;
    end
  end

endmodule

//--- logic/fetch_stage.sv
module fetch_stage #(
  parameter int IMEM_ADDR_W = 8
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   imem_we,
  input  logic [IMEM_ADDR_W-1:0] imem_addr,
  input  cpu_pkg::word_t         imem_wdata,
  input  logic                   halt_instr,
  input  logic                   take_branch,
  input  cpu_pkg::word_t         branch_target,
  output cpu_pkg::word_t         instr,
  output cpu_pkg::word_t         pc,
  output cpu_pkg::word_t         pc_plus2,
  output logic                   hlt
);

  // Sticky halt, set on the edge that ends the HLT cycle
  logic halted_q;
  cpu_pkg::word_t pc_next;
  cpu_pkg::word_t imem [2**IMEM_ADDR_W];

  // Program load port, usable at any time
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  // Asynchronous read at the PC word address
  assign instr = imem[pc[IMEM_ADDR_W:1]];

  assign pc_plus2 = pc + 16'd2;

  // High in the HLT cycle itself, then held by halted_q
  assign hlt = halted_q | halt_instr;

  // Halt first, then branch, then sequential
  always_comb begin
    if (hlt) begin
      pc_next = pc;
    end else if (take_branch) begin
      pc_next = branch_target;
    end else begin
      pc_next = pc_plus2;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc       <= '0;
      halted_q <= 1'b0;
    end else begin
      pc       <= pc_next;
      halted_q <= hlt;
    end
  end

endmodule

//--- logic/cpu_pkg.sv
package cpu_pkg;

  // Data and address word, byte addressed PC
  typedef logic [15:0] word_t;
  typedef logic [3:0] reg_idx_t;

  // Instruction bits 15 to 12; code 7 is a no-op
  typedef enum logic [3:0] {
    OP_ADD = 4'h0,
    OP_SUB = 4'h1,
    OP_XOR = 4'h2,
    OP_AND = 4'h3,
    OP_SLL = 4'h4,
    OP_SRA = 4'h5,
    OP_ROR = 4'h6,
    OP_LW  = 4'h8,
    OP_SW  = 4'h9,
    OP_LLB = 4'hA,
    OP_LHB = 4'hB,
    OP_B   = 4'hC,
    OP_BR  = 4'hD,
    OP_PCS = 4'hE,
    OP_HLT = 4'hF
  } opcode_e;

  // Branch condition, bits 11 to 9 of B and BR
  typedef enum logic [2:0] {
    COND_NE = 3'd0,
    COND_EQ = 3'd1,
    COND_GT = 3'd2,
    COND_LT = 3'd3,
    COND_GE = 3'd4,
    COND_LE = 3'd5,
    COND_OV = 3'd6,
    COND_AL = 3'd7
  } cond_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_AND, ALU_SLL, ALU_SRA, ALU_ROR, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {BR_NONE, BR_B, BR_REG} branch_kind_e;
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC2} wb_sel_e;

  // N, V, Z from high bit to low bit
  typedef struct packed {
    logic n;
    logic v;
    logic z;
  } flags_t;

endpackage
